//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = frame_path_tb
FILELIST  = list.f
OBJ_DIR   = obj_dir
BIN       = $(OBJ_DIR)/V$(TOP)
PASS_MSG  = test passed

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the simulation passes only if the pass message shows up in its output
run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- list.f
rtl/frame_pkg.sv
rtl/frame_check.sv
rtl/frame_fifo.sv
rtl/frame_stats.sv
rtl/frame_path_top.sv
testbench/frame_path_tb.sv

//--- rtl/frame_check.sv
`timescale 1ns/1ps
`default_nettype none

module frame_check
  import frame_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  input  logic [data_width-1:0] in_tdata,
  input  logic                  in_tvalid,
  output logic                  in_tready,
  input  logic                  in_tlast,
  input  logic                  in_tuser,
  output logic [data_width-1:0] chk_tdata,
  output logic                  chk_tvalid,
  input  logic                  chk_tready,
  output logic                  chk_tlast,
  output logic                  chk_tuser
);

  // beats accepted so far in the current frame, not counting this one
  logic [len_width-1:0] beat_cnt;
  logic                 err_seen;
  logic                 accept;
  logic                 frame_bad;

  assign in_tready = ~chk_tvalid | chk_tready;
  assign accept    = in_tvalid & in_tready;

  // only meaningful on the last beat, where the count plus this beat is the length
  assign frame_bad = (beat_cnt < len_width'(min_frame_len - 1)) | err_seen | in_tuser;

  ////////////////////////////////////////////////////////////////////////////
  // per-frame length and error tracking
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      beat_cnt <= '0;
      err_seen <= 1'b0;
    end else if (accept) begin
      if (in_tlast) begin
        beat_cnt <= '0;
        err_seen <= 1'b0;
      end else begin
        // saturate so a very long frame never wraps back into a runt
        if (beat_cnt != '1) begin
          beat_cnt <= beat_cnt + 1'b1;
        end
        err_seen <= err_seen | in_tuser;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // one-entry register slice
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      chk_tvalid <= 1'b0;
    end else if (in_tready) begin
      chk_tvalid <= in_tvalid;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      chk_tdata <= in_tdata;
      chk_tlast <= in_tlast;
      chk_tuser <= in_tlast & frame_bad;
    end
  end

  // a stalled beat must not change until the FIFO takes it
  a_hold_when_stalled: assert property (
    @(posedge clk) disable iff (rst)
      chk_tvalid && !chk_tready |=> chk_tvalid && $stable(chk_tdata) &&
                                    $stable(chk_tlast) && $stable(chk_tuser)
  );

endmodule

`default_nettype wire

//--- rtl/frame_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module frame_fifo
  import frame_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  input  logic [data_width-1:0] chk_tdata,
  input  logic                  chk_tvalid,
  output logic                  chk_tready,
  input  logic                  chk_tlast,
  input  logic                  chk_tuser,
  output logic [data_width-1:0] fifo_tdata,
  output logic                  fifo_tvalid,
  input  logic                  fifo_tready,
  output logic                  fifo_tlast,
  output logic                  frame_rejected,
  output logic                  frame_dropped
);

  // each entry holds tlast above the data byte
  logic [data_width:0]      mem [fifo_depth];
  logic [data_width:0]      out_reg;

  // one extra bit on every pointer tells full from empty
  logic [fifo_addr_width:0] wr_ptr;
  logic [fifo_addr_width:0] wr_ptr_cur;
  logic [fifo_addr_width:0] rd_ptr;
  logic [fifo_addr_width:0] commit_level;

  fifo_wr_state_t           wr_state;

  logic                     write;
  logic                     full_cur;
  logic                     store_beat;
  logic                     empty;
  logic                     read;

  // frames that do not fit are dropped, so the input never stalls
  assign chk_tready = 1'b1;
  assign write      = chk_tvalid & chk_tready;

  assign full_cur = (wr_ptr_cur[fifo_addr_width] != rd_ptr[fifo_addr_width]) &&
                    (wr_ptr_cur[fifo_addr_width-1:0] == rd_ptr[fifo_addr_width-1:0]);
  assign store_beat = write && (wr_state == wr_store) && !full_cur;

  // the reader only sees frames whose last beat has been committed
  assign empty        = (wr_ptr == rd_ptr);
  assign read         = (~fifo_tvalid | fifo_tready) & ~empty;
  assign commit_level = wr_ptr - rd_ptr;

  assign {fifo_tlast, fifo_tdata} = out_reg;

  ////////////////////////////////////////////////////////////////////////////
  // write side
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr         <= '0;
      wr_ptr_cur     <= '0;
      wr_state       <= wr_store;
      frame_rejected <= 1'b0;
      frame_dropped  <= 1'b0;
    end else begin
      frame_rejected <= 1'b0;
      frame_dropped  <= 1'b0;
      if (store_beat) begin
        if (chk_tlast && chk_tuser) begin
          // a bad frame throws away everything written since the last commit
          wr_ptr_cur     <= wr_ptr;
          frame_rejected <= 1'b1;
        end else if (chk_tlast) begin
          wr_ptr     <= wr_ptr_cur + 1'b1;
          wr_ptr_cur <= wr_ptr_cur + 1'b1;
        end else begin
          wr_ptr_cur <= wr_ptr_cur + 1'b1;
        end
      end else if (write) begin
        // no room, or already discarding the rest of an overflowed frame
        if (chk_tlast) begin
          wr_ptr_cur    <= wr_ptr;
          wr_state      <= wr_store;
          frame_dropped <= 1'b1;
        end else begin
          wr_state <= wr_discard;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (store_beat) begin
      mem[wr_ptr_cur[fifo_addr_width-1:0]] <= {chk_tlast, chk_tdata};
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // read side with registered output
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_ptr <= '0;
    end else if (read) begin
      rd_ptr <= rd_ptr + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (read) begin
      out_reg <= mem[rd_ptr[fifo_addr_width-1:0]];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      fifo_tvalid <= 1'b0;
    end else if (~fifo_tvalid | fifo_tready) begin
      fifo_tvalid <= ~empty;
    end
  end

  a_rd_behind_commit: assert property (
    @(posedge clk) disable iff (rst) commit_level <= fifo_depth
  );

  // a frame ends either rejected or dropped, never both
  a_one_outcome: assert property (
    @(posedge clk) disable iff (rst) !(frame_rejected && frame_dropped)
  );

endmodule

`default_nettype wire

//--- rtl/frame_path_top.sv
`timescale 1ns/1ps
`default_nettype none

module frame_path_top
  import frame_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  input  logic [data_width-1:0] in_tdata,
  input  logic                  in_tvalid,
  output logic                  in_tready,
  input  logic                  in_tlast,
  input  logic                  in_tuser,
  output logic [data_width-1:0] out_tdata,
  output logic                  out_tvalid,
  input  logic                  out_tready,
  output logic                  out_tlast,
  output logic [cnt_width-1:0]  frames_out,
  output logic [cnt_width-1:0]  bytes_out,
  output logic [cnt_width-1:0]  frames_rejected,
  output logic [cnt_width-1:0]  frames_dropped
);

  // check stage to frame FIFO
  logic [data_width-1:0] chk_tdata;
  logic                  chk_tvalid;
  logic                  chk_tready;
  logic                  chk_tlast;
  logic                  chk_tuser;

  // frame FIFO to stats stage
  logic [data_width-1:0] fifo_tdata;
  logic                  fifo_tvalid;
  logic                  fifo_tready;
  logic                  fifo_tlast;
  logic                  frame_rejected;
  logic                  frame_dropped;

  frame_check check0 (
    .clk        (clk),
    .rst        (rst),
    .in_tdata   (in_tdata),
    .in_tvalid  (in_tvalid),
    .in_tready  (in_tready),
    .in_tlast   (in_tlast),
    .in_tuser   (in_tuser),
    .chk_tdata  (chk_tdata),
    .chk_tvalid (chk_tvalid),
    .chk_tready (chk_tready),
    .chk_tlast  (chk_tlast),
    .chk_tuser  (chk_tuser)
  );

  frame_fifo fifo0 (
    .clk            (clk),
    .rst            (rst),
    .chk_tdata      (chk_tdata),
    .chk_tvalid     (chk_tvalid),
    .chk_tready     (chk_tready),
    .chk_tlast      (chk_tlast),
    .chk_tuser      (chk_tuser),
    .fifo_tdata     (fifo_tdata),
    .fifo_tvalid    (fifo_tvalid),
    .fifo_tready    (fifo_tready),
    .fifo_tlast     (fifo_tlast),
    .frame_rejected (frame_rejected),
    .frame_dropped  (frame_dropped)
  );

  frame_stats stats0 (
    .clk                 (clk),
    .rst                 (rst),
    .fifo_tdata          (fifo_tdata),
    .fifo_tvalid         (fifo_tvalid),
    .fifo_tready         (fifo_tready),
    .fifo_tlast          (fifo_tlast),
    .frame_rejected      (frame_rejected),
    .frame_dropped       (frame_dropped),
    .out_tdata           (out_tdata),
    .out_tvalid          (out_tvalid),
    .out_tready          (out_tready),
    .out_tlast           (out_tlast),
    .frames_out          (frames_out),
    .bytes_out           (bytes_out),
    .frames_rejected_cnt (frames_rejected),
    .frames_dropped_cnt  (frames_dropped)
  );

endmodule

`default_nettype wire

//--- rtl/frame_pkg.sv
`default_nettype none

package frame_pkg;

  // byte lane and frame buffer sizing
  localparam int data_width      = 8;
  localparam int fifo_addr_width = 4;
  localparam int fifo_depth      = 1 << fifo_addr_width;

  // frames shorter than this are runts and get rejected
  localparam int min_frame_len   = 4;

  localparam int len_width       = 16;
  localparam int cnt_width       = 16;

  typedef enum logic {
    wr_store,
    wr_discard
  } fifo_wr_state_t;

endpackage

`default_nettype wire

//--- rtl/frame_stats.sv
`timescale 1ns/1ps
`default_nettype none

module frame_stats
  import frame_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  input  logic [data_width-1:0] fifo_tdata,
  input  logic                  fifo_tvalid,
  output logic                  fifo_tready,
  input  logic                  fifo_tlast,
  input  logic                  frame_rejected,
  input  logic                  frame_dropped,
  output logic [data_width-1:0] out_tdata,
  output logic                  out_tvalid,
  input  logic                  out_tready,
  output logic                  out_tlast,
  output logic [cnt_width-1:0]  frames_out,
  output logic [cnt_width-1:0]  bytes_out,
  output logic [cnt_width-1:0]  frames_rejected_cnt,
  output logic [cnt_width-1:0]  frames_dropped_cnt
);

  logic in_fire;
  logic out_fire;

  assign fifo_tready = ~out_tvalid | out_tready;
  assign in_fire     = fifo_tvalid & fifo_tready;
  assign out_fire    = out_tvalid & out_tready;

  ////////////////////////////////////////////////////////////////////////////
  // output register slice
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      out_tvalid <= 1'b0;
    end else if (fifo_tready) begin
      out_tvalid <= fifo_tvalid;
    end
  end

  always_ff @(posedge clk) begin
    if (in_fire) begin
      out_tdata <= fifo_tdata;
      out_tlast <= fifo_tlast;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // statistics counters that wrap at cnt_width
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      frames_out          <= '0;
      bytes_out           <= '0;
      frames_rejected_cnt <= '0;
      frames_dropped_cnt  <= '0;
    end else begin
      // delivered traffic is counted where it leaves the block
      if (out_fire) begin
        bytes_out <= bytes_out + 1'b1;
        if (out_tlast) begin
          frames_out <= frames_out + 1'b1;
        end
      end
      if (frame_rejected) begin
        frames_rejected_cnt <= frames_rejected_cnt + 1'b1;
      end
      if (frame_dropped) begin
        frames_dropped_cnt <= frames_dropped_cnt + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- testbench/frame_path_tb.sv
`timescale 1ns/1ps
`default_nettype none

module frame_path_tb
  import frame_pkg::*;
();

  localparam int num_frames     = 26;
  localparam int beat_timeout   = 100;
  localparam int settle_timeout = 2000;

  typedef enum int {deliver, reject, drop} outcome_t;

  // per frame the length, the 1-based beat carrying in_tuser (0 for none) and the outcome
  int frame_len [num_frames] = '{4, 5, 16, 1, 2, 3, 8, 6, 10, 16, 17, 12, 40,
                                 4, 20, 7, 25, 9, 3, 15, 33, 16, 11, 13, 6, 14};
  int err_beat [num_frames] = '{0, 0, 0, 0, 0, 0, 3, 6, 1, 16, 0, 0, 0,
                                0, 5, 0, 25, 0, 2, 0, 0, 0, 0, 0, 0, 0};
  outcome_t frame_outcome [num_frames] = '{
    deliver, deliver, deliver, reject, reject, reject, reject, reject, reject,
    reject, drop, deliver, drop, deliver, drop, deliver, drop, deliver, reject,
    deliver, drop, deliver, deliver, deliver, deliver, deliver
  };

  logic                  clk = 1'b0;
  logic                  rst;
  logic [data_width-1:0] in_tdata;
  logic                  in_tvalid;
  logic                  in_tready;
  logic                  in_tlast;
  logic                  in_tuser;
  logic [data_width-1:0] out_tdata;
  logic                  out_tvalid;
  logic                  out_tready;
  logic                  out_tlast;
  logic [cnt_width-1:0]  frames_out;
  logic [cnt_width-1:0]  bytes_out;
  logic [cnt_width-1:0]  frames_rejected;
  logic [cnt_width-1:0]  frames_dropped;

  logic [31:0]           lfsr = 32'hf4e327b1;
  // each scoreboard entry is tlast above the expected byte
  logic [data_width:0]   scoreboard [$];
  logic [data_width:0]   exp_beat;

  always #5 clk = ~clk;

  frame_path_top dut0 (
    .clk             (clk),
    .rst             (rst),
    .in_tdata        (in_tdata),
    .in_tvalid       (in_tvalid),
    .in_tready       (in_tready),
    .in_tlast        (in_tlast),
    .in_tuser        (in_tuser),
    .out_tdata       (out_tdata),
    .out_tvalid      (out_tvalid),
    .out_tready      (out_tready),
    .out_tlast       (out_tlast),
    .frames_out      (frames_out),
    .bytes_out       (bytes_out),
    .frames_rejected (frames_rejected),
    .frames_dropped  (frames_dropped)
  );

  ////////////////////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////////////////////

  // 32-bit Fibonacci LFSR with taps 32, 22, 2, 1
  function automatic logic take_bit();
    logic fb;
    fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
    lfsr = {lfsr[30:0], fb};
    return fb;
  endfunction

  function automatic logic [data_width-1:0] random_byte();
    logic [data_width-1:0] b;
    for (int k = 0; k < data_width; k++) begin
      b[k] = take_bit();
    end
    return b;
  endfunction

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("test failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      fail_run($sformatf("Mismatch at %0t: %s expected %0h, got %0h",
                         $time, name, expected, actual));
    end
  endtask

  task automatic send_frame(input int idx);
    int  waited;
    logic accepted;
    for (int beat = 1; beat <= frame_len[idx]; beat++) begin
      // an input gap before roughly a quarter of the beats
      while (take_bit() & take_bit()) begin
        in_tvalid = 1'b0;
        @(negedge clk);
      end
      in_tvalid = 1'b1;
      in_tdata  = random_byte();
      in_tlast  = (beat == frame_len[idx]);
      in_tuser  = (beat == err_beat[idx]);
      if (frame_outcome[idx] == deliver) begin
        scoreboard.push_back({in_tlast, in_tdata});
      end
      accepted = 1'b0;
      waited   = 0;
      while (!accepted) begin
        @(posedge clk);
        accepted = in_tready;
        @(negedge clk);
        waited++;
        if (!accepted && waited > beat_timeout) begin
          fail_run($sformatf("input beat %0d of frame %0d was never accepted", beat, idx));
        end
      end
    end
    in_tvalid = 1'b0;
    in_tlast  = 1'b0;
    in_tuser  = 1'b0;
  endtask

  task automatic wait_for_outcome(input int sent);
    int waited;
    waited = 0;
    while (32'(frames_out) + 32'(frames_rejected) + 32'(frames_dropped) != sent) begin
      @(negedge clk);
      waited++;
      if (waited > settle_timeout) begin
        fail_run($sformatf("frame %0d was never delivered, rejected or dropped", sent - 1));
      end
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // output side
  ////////////////////////////////////////////////////////////////////////////

  always @(negedge clk) begin
    if (rst) begin
      out_tready = 1'b0;
    end else begin
      out_tready = take_bit() | take_bit();
    end
  end

  always @(posedge clk) begin
    if (!rst && out_tvalid && out_tready) begin
      if (scoreboard.size() == 0) begin
        fail_run("the DUT sent an output beat that no frame should have produced");
      end else begin
        exp_beat = scoreboard.pop_front();
        check_value("out_tdata", 32'(exp_beat[data_width-1:0]), 32'(out_tdata));
        check_value("out_tlast", 32'(exp_beat[data_width]), 32'(out_tlast));
      end
    end
  end

  initial begin
    int exp_frames;
    int exp_bytes;
    int exp_rej;
    int exp_drop;
    int tot_frames;
    int tot_bytes;
    int tot_rej;
    int tot_drop;
    rst        = 1'b1;
    in_tdata   = '0;
    in_tvalid  = 1'b0;
    in_tlast   = 1'b0;
    in_tuser   = 1'b0;
    out_tready = 1'b0;
    exp_frames = 0;
    exp_bytes  = 0;
    exp_rej    = 0;
    exp_drop   = 0;
    tot_frames = 0;
    tot_bytes  = 0;
    tot_rej    = 0;
    tot_drop   = 0;
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    check_value("out_tvalid", 0, 32'(out_tvalid));
    check_value("frames_out", 0, 32'(frames_out));
    check_value("bytes_out", 0, 32'(bytes_out));
    check_value("frames_rejected", 0, 32'(frames_rejected));
    check_value("frames_dropped", 0, 32'(frames_dropped));

    // an overlong frame is dropped even when errored since the overflow comes before tlast
    for (int i = 0; i < num_frames; i++) begin
      if (frame_len[i] > fifo_depth) begin
        tot_drop += 1;
      end else if (frame_len[i] < min_frame_len || err_beat[i] != 0) begin
        tot_rej += 1;
      end else begin
        tot_frames += 1;
        tot_bytes  += frame_len[i];
      end
    end

    // each frame settles before the next one starts, so the FIFO is empty each time
    for (int i = 0; i < num_frames; i++) begin
      send_frame(i);
      case (frame_outcome[i])
        deliver: begin
          exp_frames += 1;
          exp_bytes  += frame_len[i];
        end
        reject:  exp_rej += 1;
        default: exp_drop += 1;
      endcase
      wait_for_outcome(i + 1);
      check_value("frames_out", exp_frames, 32'(frames_out));
      check_value("bytes_out", exp_bytes, 32'(bytes_out));
      check_value("frames_rejected", exp_rej, 32'(frames_rejected));
      check_value("frames_dropped", exp_drop, 32'(frames_dropped));
    end

    check_value("scoreboard size", 0, scoreboard.size());
    check_value("frames_out", tot_frames, 32'(frames_out));
    check_value("bytes_out", tot_bytes, 32'(bytes_out));
    check_value("frames_rejected", tot_rej, 32'(frames_rejected));
    check_value("frames_dropped", tot_drop, 32'(frames_dropped));
    $display("test passed");
    $finish;
  end

endmodule

`default_nettype wire
